// File: fwd_gen_settings.svh
// Forward generator build settings
`ifndef FWD_GEN_SETTINGS_SVH
`define FWD_GEN_SETTINGS_SVH

// ------------------------------------------------------------------------
// Datapath widths
// ------------------------------------------------------------------------
// Vertex index and walk counter
`define FWD_INDEX_WIDTH 32

// Array base pointer and byte offset
`define FWD_ADDR_WIDTH 64

`define FWD_ROUTE_WIDTH 8

// Offset shift amount, up to 31 positions
`define FWD_SHIFT_WIDTH 5

// ------------------------------------------------------------------------
// Request FIFO
// ------------------------------------------------------------------------
`define FWD_FIFO_DEPTH 16

// Fill level that stalls the sequencer
`define FWD_PROG_THRESH 8

`endif

// File: fwd_gen_pkg.sv
// Forward generator shared types
`include "fwd_gen_settings.svh"

package fwd_gen_pkg;

    // ------------------------------------------------------------------------
    // Vector types
    // ------------------------------------------------------------------------
    // One vertex index or counter value
    typedef logic [`FWD_INDEX_WIDTH-1:0] index_t;

    // Base pointer or byte offset
    typedef logic [`FWD_ADDR_WIDTH-1:0] address_t;

    typedef logic [`FWD_ROUTE_WIDTH-1:0] route_t;

    typedef logic [`FWD_SHIFT_WIDTH-1:0] shift_t;

    // ------------------------------------------------------------------------
    // State machines
    // ------------------------------------------------------------------------
    // Configuration fetch in the decode stage
    typedef enum logic [2:0] {
        SETUP_IDLE,
        SETUP_MEM_REQ,
        SETUP_MEM_WAIT,
        SETUP_ENG_REQ,
        SETUP_ENG_WAIT,
        SETUP_RUN
    } setup_state_e;

    // Index walk in the execute stage
    typedef enum logic [2:0] {
        SEQ_IDLE,
        SEQ_LOAD,
        SEQ_BUSY,
        SEQ_PAUSE,
        SEQ_DONE
    } seq_state_e;

endpackage : fwd_gen_pkg

// File: fwd_request_fifo.sv
// Synchronous request FIFO
`timescale 1ns/1ps

module fwd_request_fifo #(
    parameter int DEPTH  = 16,
    parameter int WIDTH  = 8,
    parameter int THRESH = 8
) (
    input  logic             ap_clk,
    input  logic             areset_generator,
    input  logic             wr_en,
    input  logic [WIDTH-1:0] din,
    input  logic             rd_en,
    output logic [WIDTH-1:0] dout,
    output logic             valid,
    output logic             empty,
    output logic             full,
    output logic             prog_full
);

    localparam int AW = (DEPTH > 1) ? $clog2(DEPTH) : 1;

    logic [WIDTH-1:0] mem [DEPTH];
    logic [AW-1:0]    wr_ptr;
    logic [AW-1:0]    rd_ptr;
    logic [AW:0]      count;
    logic             do_wr;
    logic             do_rd;

    assign empty     = (count == '0);
    assign full      = (count == (AW+1)'(DEPTH));
    assign prog_full = (count >= (AW+1)'(THRESH));
    assign do_wr     = wr_en & ~full;
    assign do_rd     = rd_en & ~empty;

    // ------------------------------------------------------------------------
    // Pointers and occupancy
    // ------------------------------------------------------------------------
    always_ff @(posedge ap_clk) begin
        if (areset_generator) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
            valid  <= 1'b0;
        end else begin
            if (do_wr) begin
                wr_ptr <= (wr_ptr == AW'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (do_rd) begin
                rd_ptr <= (rd_ptr == AW'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            case ({do_wr, do_rd})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
            valid <= do_rd;
        end
    end

    // Storage and registered read port
    always_ff @(posedge ap_clk) begin
        if (do_wr) begin
            mem[wr_ptr] <= din;
        end
        if (do_rd) begin
            dout <= mem[rd_ptr];
        end
    end

    // Upstream pause must keep writes away from a full FIFO
    a_no_write_when_full: assert property (
        @(posedge ap_clk) disable iff (areset_generator) full |-> !wr_en
    );

    // Reads are requested only while entries are stored
    a_no_read_when_empty: assert property (
        @(posedge ap_clk) disable iff (areset_generator) rd_en |-> !empty
    );

endmodule : fwd_request_fifo

// File: fwd_config_decode.sv
// Configuration decode stage
`timescale 1ns/1ps

module fwd_config_decode
    import fwd_gen_pkg::*;
(
    input  logic     ap_clk,
    input  logic     areset_generator,
    input  logic     descriptor_valid,
    input  logic     config_memory_valid,
    input  logic     mode_indirect,
    input  address_t array_pointer_in,
    input  index_t   index_start,
    input  index_t   index_end,
    input  index_t   stride,
    input  logic     count_down,
    input  logic     shift_left_in,
    input  shift_t   shift_amount_in,
    input  route_t   route_in,
    input  logic     config_engine_valid,
    input  index_t   engine_index_start,
    input  index_t   engine_index_end,
    input  logic     walk_done,
    output logic     config_memory_setup,
    output logic     config_engine_setup,
    output logic     walk_start,
    output index_t   walk_start_index,
    output index_t   walk_end_index,
    output index_t   walk_stride,
    output logic     walk_count_down,
    output address_t array_pointer,
    output logic     shift_left,
    output shift_t   shift_amount,
    output route_t   route
);

    setup_state_e state;
    setup_state_e next_state;
    logic         descriptor_valid_reg;
    logic         mem_accept;
    logic         eng_accept;

    // ------------------------------------------------------------------------
    // Setup state machine
    // ------------------------------------------------------------------------
    always_ff @(posedge ap_clk) begin
        if (areset_generator) begin
            state                <= SETUP_IDLE;
            descriptor_valid_reg <= 1'b0;
            walk_start           <= 1'b0;
        end else begin
            state                <= next_state;
            descriptor_valid_reg <= descriptor_valid;
            // Last configuration seen, so the walk can begin
            walk_start           <= (mem_accept & ~mode_indirect) | eng_accept;
        end
    end

    always_comb begin
        next_state = state;
        case (state)
            SETUP_IDLE: begin
                if (descriptor_valid_reg) begin
                    next_state = SETUP_MEM_REQ;
                end
            end
            SETUP_MEM_REQ: next_state = SETUP_MEM_WAIT;
            SETUP_MEM_WAIT: begin
                if (config_memory_valid) begin
                    next_state = mode_indirect ? SETUP_ENG_REQ : SETUP_RUN;
                end
            end
            SETUP_ENG_REQ: next_state = SETUP_ENG_WAIT;
            SETUP_ENG_WAIT: begin
                if (config_engine_valid) begin
                    next_state = SETUP_RUN;
                end
            end
            SETUP_RUN: begin
                if (walk_done) begin
                    next_state = SETUP_IDLE;
                end
            end
            default: next_state = SETUP_IDLE;
        endcase
    end

    // One pulse per request state
    assign config_memory_setup = (state == SETUP_MEM_REQ);
    assign config_engine_setup = (state == SETUP_ENG_REQ);

    assign mem_accept = (state == SETUP_MEM_WAIT) & config_memory_valid;
    assign eng_accept = (state == SETUP_ENG_WAIT) & config_engine_valid;

    // ------------------------------------------------------------------------
    // Walk parameters
    // ------------------------------------------------------------------------
    always_ff @(posedge ap_clk) begin
        if (mem_accept) begin
            walk_start_index <= index_start;
            walk_end_index   <= index_end;
            walk_stride      <= stride;
            walk_count_down  <= count_down;
            array_pointer    <= array_pointer_in;
            shift_left       <= shift_left_in;
            shift_amount     <= shift_amount_in;
            route            <= route_in;
        end
        // Indirect mode takes its range from the engine side
        if (eng_accept) begin
            walk_start_index <= engine_index_start;
            walk_end_index   <= engine_index_end;
        end
    end

endmodule : fwd_config_decode

// File: fwd_index_sequencer.sv
// Index walk sequencer
`timescale 1ns/1ps

module fwd_index_sequencer
    import fwd_gen_pkg::*;
(
    input  logic   ap_clk,
    input  logic   areset_generator,
    input  logic   walk_start,
    input  index_t walk_start_index,
    input  index_t walk_end_index,
    input  index_t walk_stride,
    input  logic   walk_count_down,
    input  logic   prog_full,
    output logic   index_valid,
    output index_t index_value,
    output logic   walk_done,
    output logic   done
);

    seq_state_e                state;
    seq_state_e                next_state;
    index_t                    counter;
    logic                      wrapped;
    logic                      range_ok;
    logic [$bits(index_t):0]   step_sum;

    // ------------------------------------------------------------------------
    // Range test and step
    // ------------------------------------------------------------------------
    // A carry or borrow out of the counter ends the walk as well
    always_comb begin
        if (walk_count_down) begin
            range_ok = ~wrapped & (counter > walk_end_index);
            step_sum = {1'b0, counter} - {1'b0, walk_stride};
        end else begin
            range_ok = ~wrapped & (counter < walk_end_index);
            step_sum = {1'b0, counter} + {1'b0, walk_stride};
        end
    end

    assign index_valid = (state == SEQ_BUSY) & range_ok & ~prog_full;
    assign index_value = counter;
    assign walk_done   = (state == SEQ_DONE);

    always_ff @(posedge ap_clk) begin
        if (state == SEQ_LOAD) begin
            counter <= walk_start_index;
            wrapped <= 1'b0;
        end else if (index_valid) begin
            counter <= step_sum[$bits(index_t)-1:0];
            wrapped <= step_sum[$bits(index_t)];
        end
    end

    // ------------------------------------------------------------------------
    // Walk state machine
    // ------------------------------------------------------------------------
    always_ff @(posedge ap_clk) begin
        if (areset_generator) begin
            state <= SEQ_IDLE;
            done  <= 1'b1;
        end else begin
            state <= next_state;
            if (walk_start) begin
                done <= 1'b0;
            end else if (state == SEQ_BUSY && !range_ok) begin
                done <= 1'b1;
            end
        end
    end

    always_comb begin
        next_state = state;
        case (state)
            SEQ_IDLE: begin
                if (walk_start) begin
                    next_state = SEQ_LOAD;
                end
            end
            SEQ_LOAD: next_state = SEQ_BUSY;
            SEQ_BUSY: begin
                if (!range_ok) begin
                    next_state = SEQ_DONE;
                end else if (prog_full) begin
                    next_state = SEQ_PAUSE;
                end
            end
            // Hold until the FIFO drains below threshold
            SEQ_PAUSE: begin
                if (!prog_full) begin
                    next_state = SEQ_BUSY;
                end
            end
            SEQ_DONE: next_state = SEQ_IDLE;
            default: next_state = SEQ_IDLE;
        endcase
    end

    // A new walk only starts once the previous one has finished
    a_start_between_walks: assert property (
        @(posedge ap_clk) disable iff (areset_generator)
        walk_start |-> (state == SEQ_IDLE)
    );

endmodule : fwd_index_sequencer

// File: fwd_request_former.sv
// Request result stage
`timescale 1ns/1ps
`include "fwd_gen_settings.svh"

module fwd_request_former
    import fwd_gen_pkg::*;
(
    input  logic     ap_clk,
    input  logic     areset_generator,
    input  logic     index_valid,
    input  index_t   index_value,
    input  address_t array_pointer,
    input  logic     shift_left,
    input  shift_t   shift_amount,
    input  route_t   route,
    input  logic     request_rd_en,
    output logic     prog_full,
    output logic     request_valid,
    output route_t   request_route,
    output address_t request_base,
    output address_t request_offset,
    output index_t   request_index
);

    // Route, base, offset and index, most significant first
    localparam int PACKET_WIDTH =
        $bits(route_t) + 2 * $bits(address_t) + $bits(index_t);

    address_t                index_wide;
    address_t                offset_comb;
    logic                    packet_valid;
    logic [PACKET_WIDTH-1:0] packet_data;
    logic [PACKET_WIDTH-1:0] fifo_dout;
    logic                    fifo_empty;
    logic                    fifo_rd_en;

    // ------------------------------------------------------------------------
    // Offset and packet register
    // ------------------------------------------------------------------------
    assign index_wide  = address_t'(index_value);
    assign offset_comb = shift_left ? (index_wide << shift_amount)
                                    : (index_wide >> shift_amount);

    always_ff @(posedge ap_clk) begin
        if (areset_generator) begin
            packet_valid <= 1'b0;
        end else begin
            packet_valid <= index_valid;
        end
    end

    always_ff @(posedge ap_clk) begin
        packet_data <= {route, array_pointer, offset_comb, index_value};
    end

    // ------------------------------------------------------------------------
    // Request queue
    // ------------------------------------------------------------------------
    // Pops on an empty queue are dropped here
    assign fifo_rd_en = request_rd_en & ~fifo_empty;

    fwd_request_fifo #(
        .DEPTH  (`FWD_FIFO_DEPTH),
        .WIDTH  (PACKET_WIDTH),
        .THRESH (`FWD_PROG_THRESH)
    ) u_request_fifo (
        .ap_clk           (ap_clk),
        .areset_generator (areset_generator),
        .wr_en            (packet_valid),
        .din              (packet_data),
        .rd_en            (fifo_rd_en),
        .dout             (fifo_dout),
        .valid            (request_valid),
        .empty            (fifo_empty),
        .full             (),
        .prog_full        (prog_full)
    );

    assign {request_route, request_base, request_offset, request_index} = fifo_dout;

endmodule : fwd_request_former

// File: fwd_data_generator.sv
// CSR index generator top level
`timescale 1ns/1ps

module fwd_data_generator
    import fwd_gen_pkg::*;
(
    input  logic     ap_clk,
    input  logic     areset_generator,
    input  logic     descriptor_valid,
    input  logic     config_memory_valid,
    input  logic     mode_indirect,
    input  address_t array_pointer,
    input  index_t   index_start,
    input  index_t   index_end,
    input  index_t   stride,
    input  logic     count_down,
    input  logic     shift_left,
    input  shift_t   shift_amount,
    input  route_t   route,
    input  logic     config_engine_valid,
    input  index_t   engine_index_start,
    input  index_t   engine_index_end,
    input  logic     request_rd_en,
    output logic     config_memory_setup,
    output logic     config_engine_setup,
    output logic     request_valid,
    output route_t   request_route,
    output address_t request_base,
    output address_t request_offset,
    output index_t   request_index,
    output logic     done
);

    // ------------------------------------------------------------------------
    // Stage handoff wires
    // ------------------------------------------------------------------------
    // Decode to sequencer
    logic     walk_start;
    index_t   walk_start_index;
    index_t   walk_end_index;
    index_t   walk_stride;
    logic     walk_count_down;
    logic     walk_done;

    // Decode to former, held for the whole walk
    address_t cfg_array_pointer;
    logic     cfg_shift_left;
    shift_t   cfg_shift_amount;
    route_t   cfg_route;

    // Sequencer and former
    logic     index_valid;
    index_t   index_value;
    logic     prog_full;

    fwd_config_decode u_config_decode (
        .*,
        .array_pointer_in (array_pointer),
        .shift_left_in    (shift_left),
        .shift_amount_in  (shift_amount),
        .route_in         (route),
        .array_pointer    (cfg_array_pointer),
        .shift_left       (cfg_shift_left),
        .shift_amount     (cfg_shift_amount),
        .route            (cfg_route)
    );

    fwd_index_sequencer u_index_sequencer (
        .*
    );

    fwd_request_former u_request_former (
        .*,
        .array_pointer (cfg_array_pointer),
        .shift_left    (cfg_shift_left),
        .shift_amount  (cfg_shift_amount),
        .route         (cfg_route)
    );

endmodule : fwd_data_generator

// File: tb_fwd_data_generator.sv
// CSR index generator testbench
`timescale 1ns/1ps

module tb_fwd_data_generator
    import fwd_gen_pkg::*;
();

    // Longest walks summed over all tests, and the cycle budget from them
    localparam int MAX_REQUESTS = 100;
    localparam int NUM_TESTS    = 6;
    localparam int CYCLE_LIMIT  = 10 * MAX_REQUESTS + 200 * NUM_TESTS;

    logic     ap_clk;
    logic     areset_generator;
    logic     descriptor_valid;
    logic     config_memory_valid;
    logic     mode_indirect;
    address_t array_pointer;
    index_t   index_start;
    index_t   index_end;
    index_t   stride;
    logic     count_down;
    logic     shift_left;
    shift_t   shift_amount;
    route_t   route;
    logic     config_engine_valid;
    index_t   engine_index_start;
    index_t   engine_index_end;
    logic     request_rd_en;
    logic     config_memory_setup;
    logic     config_engine_setup;
    logic     request_valid;
    route_t   request_route;
    address_t request_base;
    address_t request_offset;
    index_t   request_index;
    logic     done;

    // Walk configuration of the current test
    logic     cfg_indirect;
    index_t   cfg_first;
    index_t   cfg_last;
    index_t   cfg_eng_first;
    index_t   cfg_eng_last;
    index_t   cfg_stride;
    logic     cfg_down;
    logic     cfg_shl;
    shift_t   cfg_amount;
    address_t cfg_base;
    route_t   cfg_route;

    int       seed = 32'hd80a_2b75;
    int       cycle_count = 0;
    int       error_count = 0;
    int       test_base_errors = 0;
    int       tests_run = 0;
    int       tests_failed = 0;
    int       mem_setup_count = 0;
    int       eng_setup_count = 0;
    logic     pop_sampled = 1'b0;
    index_t   exp_index[$];
    index_t   got_index[$];
    address_t got_offset[$];
    address_t got_base[$];
    route_t   got_route[$];

    fwd_data_generator u_dut (.*);

    initial begin
        ap_clk = 1'b0;
        forever #20 ap_clk = ~ap_clk;
    end

    always @(posedge ap_clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= CYCLE_LIMIT) begin
            $display("timeout: the run did not finish within %0d cycles", CYCLE_LIMIT);
            $display("FAIL: see errors above");
            $finish;
        end
    end

    // ------------------------------------------------------------------------
    // Output monitor
    // ------------------------------------------------------------------------
    always @(posedge ap_clk) pop_sampled <= request_rd_en;

    always @(negedge ap_clk) begin
        if (!areset_generator) begin
            if (config_memory_setup) mem_setup_count++;
            if (config_engine_setup) eng_setup_count++;
            if (request_valid) begin
                assert (pop_sampled) else begin
                    $display("request_valid appeared without a pop on the cycle before");
                    error_count++;
                end
                got_index.push_back(request_index);
                got_offset.push_back(request_offset);
                got_base.push_back(request_base);
                got_route.push_back(request_route);
            end
        end
    end

    // ------------------------------------------------------------------------
    // Reference model and checks
    // ------------------------------------------------------------------------
    task automatic compare_value(input string name, input string what,
                                 input logic [63:0] expected, input logic [63:0] actual);
        assert (expected === actual) else begin
            $display("error: test %s %s expected %0h actual %0h", name, what, expected, actual);
            error_count++;
        end
    endtask

    // Wide arithmetic so a downward walk cannot wrap
    task automatic model_walk();
        longint value;
        longint last;
        longint step;
        exp_index.delete();
        value = cfg_indirect ? longint'(cfg_eng_first) : longint'(cfg_first);
        last  = cfg_indirect ? longint'(cfg_eng_last) : longint'(cfg_last);
        step  = longint'(cfg_stride);
        while (cfg_down ? (value > last) : (value < last)) begin
            exp_index.push_back(index_t'(value));
            value = cfg_down ? value - step : value + step;
        end
    endtask

    function automatic address_t model_offset(input index_t idx);
        address_t wide;
        wide = address_t'(idx);
        // Each shift position doubles or halves the byte offset
        for (int i = 0; i < int'(cfg_amount); i++) begin
            wide = cfg_shl ? wide * 64'd2 : wide / 64'd2;
        end
        return wide;
    endfunction

    task automatic begin_test();
        test_base_errors = error_count;
        mem_setup_count  = 0;
        eng_setup_count  = 0;
        got_index.delete();
        got_offset.delete();
        got_base.delete();
        got_route.delete();
    endtask

    task automatic end_test(input string name);
        tests_run++;
        if (error_count == test_base_errors) begin
            $display("test %s: ok", name);
        end else begin
            tests_failed++;
            $display("test %s: %0d errors", name, error_count - test_base_errors);
        end
    endtask

    // ------------------------------------------------------------------------
    // Stimulus helpers
    // ------------------------------------------------------------------------
    task automatic set_consumer(input logic on);
        @(posedge ap_clk);
        request_rd_en <= on;
    endtask

    // Start strobe, then answer each setup pulse with its configuration
    task automatic configure_walk(input string name);
        @(posedge ap_clk);
        descriptor_valid <= 1'b1;
        @(posedge ap_clk);
        descriptor_valid <= 1'b0;
        do @(negedge ap_clk); while (!config_memory_setup);
        @(posedge ap_clk);
        config_memory_valid <= 1'b1;
        mode_indirect       <= cfg_indirect;
        array_pointer       <= cfg_base;
        index_start         <= cfg_first;
        index_end           <= cfg_last;
        stride              <= cfg_stride;
        count_down          <= cfg_down;
        shift_left          <= cfg_shl;
        shift_amount        <= cfg_amount;
        route               <= cfg_route;
        @(posedge ap_clk);
        config_memory_valid <= 1'b0;
        compare_value(name, "early engine setups", 64'(0), 64'(eng_setup_count));
        if (cfg_indirect) begin
            do @(negedge ap_clk); while (!config_engine_setup);
            @(posedge ap_clk);
            config_engine_valid <= 1'b1;
            engine_index_start  <= cfg_eng_first;
            engine_index_end    <= cfg_eng_last;
            @(posedge ap_clk);
            config_engine_valid <= 1'b0;
        end
    endtask

    task automatic wait_for_done();
        do @(negedge ap_clk); while (done);
        do @(negedge ap_clk); while (!done);
    endtask

    // Drain, allow a few cycles for stray extras, then compare in order
    task automatic collect_and_check(input string name);
        int n;
        model_walk();
        while (got_index.size() < exp_index.size()) @(negedge ap_clk);
        repeat (4) @(negedge ap_clk);
        compare_value(name, "request count", 64'(exp_index.size()), 64'(got_index.size()));
        n = (got_index.size() < exp_index.size()) ? got_index.size() : exp_index.size();
        for (int i = 0; i < n; i++) begin
            compare_value(name, "index", 64'(exp_index[i]), 64'(got_index[i]));
            compare_value(name, "offset", model_offset(exp_index[i]), got_offset[i]);
            compare_value(name, "base", cfg_base, got_base[i]);
            compare_value(name, "route", 64'(cfg_route), 64'(got_route[i]));
        end
        compare_value(name, "done", 64'(1), 64'(done));
    endtask

    task automatic set_walk(input logic indirect, input index_t first, input index_t last,
                            input index_t step, input logic down, input logic shl,
                            input shift_t amount);
        cfg_indirect  = indirect;
        cfg_first     = first;
        cfg_last      = last;
        cfg_stride    = step;
        cfg_down      = down;
        cfg_shl       = shl;
        cfg_amount    = amount;
        cfg_eng_first = '0;
        cfg_eng_last  = '0;
        cfg_base      = 64'h0000_1000_0000_0000;
        cfg_route     = 8'h5a;
    endtask

    // ------------------------------------------------------------------------
    // Directed tests
    // ------------------------------------------------------------------------
    task automatic test_after_reset();
        begin_test();
        @(negedge ap_clk);
        compare_value("after_reset", "done", 64'(1), 64'(done));
        compare_value("after_reset", "memory setup", 64'(0), 64'(config_memory_setup));
        compare_value("after_reset", "engine setup", 64'(0), 64'(config_engine_setup));
        compare_value("after_reset", "request_valid", 64'(0), 64'(request_valid));
        end_test("after_reset");
    endtask

    task automatic test_direct_up();
        begin_test();
        set_walk(1'b0, 32'd5, 32'd45, 32'd4, 1'b0, 1'b1, 5'd3);
        set_consumer(1'b1);
        configure_walk("direct_up");
        wait_for_done();
        collect_and_check("direct_up");
        compare_value("direct_up", "memory setups", 64'(1), 64'(mem_setup_count));
        compare_value("direct_up", "engine setups", 64'(0), 64'(eng_setup_count));
        end_test("direct_up");
    endtask

    task automatic test_indirect();
        begin_test();
        set_walk(1'b1, 32'd0, 32'd20, 32'd3, 1'b0, 1'b1, 5'd2);
        cfg_eng_first = 32'd100;
        cfg_eng_last  = 32'd130;
        cfg_route     = 8'hc3;
        configure_walk("indirect");
        wait_for_done();
        collect_and_check("indirect");
        compare_value("indirect", "memory setups", 64'(1), 64'(mem_setup_count));
        compare_value("indirect", "engine setups", 64'(1), 64'(eng_setup_count));
        end_test("indirect");
    endtask

    // Stride of 16 or more from below 900 keeps this walk to 50 requests
    task automatic test_down_random();
        index_t first;
        index_t step;
        first = 32'd800 + ($unsigned($random(seed)) % 100);
        step  = 32'd16 + ($unsigned($random(seed)) % 32);
        begin_test();
        set_walk(1'b0, first, 32'd100, step, 1'b1, 1'b0, 5'd1);
        cfg_base = 64'h0000_0000_dead_0000;
        configure_walk("down_random");
        wait_for_done();
        collect_and_check("down_random");
        end_test("down_random");
    endtask

    task automatic test_back_pressure();
        begin_test();
        set_walk(1'b0, 32'd0, 32'd30, 32'd1, 1'b0, 1'b1, 5'd0);
        set_consumer(1'b0);
        configure_walk("back_pressure");
        repeat (40) @(negedge ap_clk);
        // Walk must be stalled on the full queue by now
        compare_value("back_pressure", "done while held", 64'(0), 64'(done));
        compare_value("back_pressure", "requests while held", 64'(0), 64'(got_index.size()));
        set_consumer(1'b1);
        wait_for_done();
        collect_and_check("back_pressure");
        end_test("back_pressure");
    endtask

    task automatic test_empty_range();
        begin_test();
        set_walk(1'b0, 32'd50, 32'd50, 32'd2, 1'b0, 1'b1, 5'd4);
        configure_walk("empty_range");
        wait_for_done();
        collect_and_check("empty_range");
        end_test("empty_range");
    endtask

    initial begin
        areset_generator    = 1'b1;
        descriptor_valid    = 1'b0;
        config_memory_valid = 1'b0;
        mode_indirect       = 1'b0;
        array_pointer       = '0;
        index_start         = '0;
        index_end           = '0;
        stride              = '0;
        count_down          = 1'b0;
        shift_left          = 1'b0;
        shift_amount        = '0;
        route               = '0;
        config_engine_valid = 1'b0;
        engine_index_start  = '0;
        engine_index_end    = '0;
        request_rd_en       = 1'b0;
        repeat (2) @(posedge ap_clk);
        areset_generator <= 1'b0;

        test_after_reset();
        test_direct_up();
        test_indirect();
        test_down_random();
        test_back_pressure();
        test_empty_range();

        $display("tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, error_count);
        if (error_count == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule : tb_fwd_data_generator

// File: vlog.f
+incdir+.
fwd_gen_pkg.sv
fwd_request_fifo.sv
fwd_config_decode.sv
fwd_index_sequencer.sv
fwd_request_former.sv
fwd_data_generator.sv
tb_fwd_data_generator.sv

// File: Makefile
SIM      ?= verilator
TOP      ?= tb_fwd_data_generator
DUT_TOP  ?= fwd_data_generator
FILELIST ?= vlog.f
OBJ_DIR  ?= obj_dir
FLAGS    ?= --timing --assert
PASS_MSG := PASS: all tests

.PHONY: lint build sim clean

lint:
	$(SIM) --lint-only $(FLAGS) -f $(FILELIST) --top-module $(TOP)

build:
	$(SIM) --binary $(FLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(OBJ_DIR)

sim: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -qxF "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
